// File: hw/coreCtrl.sv
`timescale 1ns/1ps
`default_nettype none

module coreCtrl (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         isStoreI,
    input  wire                         isLoadI,
    input  wire                         derefRhsI,
    input  wire                         isBranchI,
    input  wire [isaPkg::WORD_W-1:0]    resultI,
    input  wire                         execDoneI,
    input  wire [isaPkg::WORD_W-1:0]    rdZI,
    output logic [isaPkg::WORD_W-1:0]   insnO,
    output logic                        execStartO,
    output logic                        rfWrEnO,
    output logic [isaPkg::WORD_W-1:0]   rfWrDataO,
    output logic [isaPkg::WORD_W-1:0]   nextPcO,
    output logic [isaPkg::WORD_W-1:0]   adrO,
    output logic [isaPkg::WORD_W-1:0]   datO,
    output logic                        wenO,
    output logic                        stbO,
    output logic                        cycO,
    input  wire [isaPkg::WORD_W-1:0]    datI,
    input  wire                         ackI,
    input  wire                         haltI
);

    corePkg::stateE             state;
    logic [isaPkg::WORD_W-1:0]  insnQ;
    logic [isaPkg::WORD_W-1:0]  rhsQ;    // exec result
    logic [isaPkg::WORD_W-1:0]  loadQ;
    logic [isaPkg::WORD_W-1:0]  nextPcQ;
    logic [isaPkg::WORD_W-1:0]  newZ;
    logic                       memAccess;

    assign memAccess = isLoadI | isStoreI;
    assign newZ      = derefRhsI ? loadQ : rhsQ;

    assign insnO      = insnQ;
    assign nextPcO    = nextPcQ;
    assign execStartO = (state == corePkg::EXEC) && !haltI; // single pulse per insn
    assign rfWrEnO    = (state == corePkg::WB) && !isStoreI;
    assign rfWrDataO  = newZ;

    assign stbO = (state == corePkg::FETCH) || (state == corePkg::MEM);
    assign cycO = stbO;
    assign wenO = (state == corePkg::MEM) && isStoreI;
    assign datO = derefRhsI ? rdZI : rhsQ; // stable while insn held

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= corePkg::FETCH;
            adrO  <= corePkg::RESET_VECTOR;
        end else begin
            case (state)
                corePkg::EXEC: begin
                    if (!haltI)
                        state <= corePkg::WAITEXEC;
                end
                corePkg::WAITEXEC: begin
                    if (execDoneI)
                        state <= corePkg::ADDR;
                end
                corePkg::ADDR: begin
                    state <= memAccess ? corePkg::MEM : corePkg::WB;
                    adrO  <= derefRhsI ? rhsQ : rdZI;
                end
                corePkg::MEM: begin
                    if (ackI)
                        state <= corePkg::WB;
                end
                corePkg::WB: begin
                    state <= corePkg::FETCH;
                    adrO  <= isBranchI ? newZ : nextPcQ; // branch on z == pc
                end
                corePkg::FETCH: begin
                    if (ackI)
                        state <= corePkg::LATCH;
                end
                corePkg::LATCH: begin
                    state <= corePkg::EXEC;
                end
                default: begin
                    state <= corePkg::FETCH;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == corePkg::WAITEXEC && execDoneI)
            rhsQ <= resultI;
        if (state == corePkg::MEM && ackI)
            loadQ <= datI;
        if (state == corePkg::FETCH && ackI)
            insnQ <= datI;
        if (state == corePkg::LATCH)
            nextPcQ <= adrO + 32'd1; // adrO still holds fetch address
    end

endmodule

`default_nettype wire

// File: hw/corePkg.sv
`default_nettype none

package corePkg;

    typedef enum logic [2:0] {
        EXEC     = 3'd0,
        WAITEXEC = 3'd1,
        ADDR     = 3'd2,
        MEM      = 3'd3,
        WB       = 3'd4,
        FETCH    = 3'd5,
        LATCH    = 3'd6
    } stateE;

    // first instruction fetch address
    localparam logic [isaPkg::WORD_W-1:0] RESET_VECTOR = 32'h0000_0100;

    // start pulse to done, in cycles
    localparam int unsigned EXEC_LAT = 4;

endpackage

`default_nettype wire

// File: hw/execUnit.sv
`timescale 1ns/1ps
`default_nettype none

module execUnit (
    input  wire                         clk,
    input  wire                         reset,
    input  wire                         startI,
    input  wire isaPkg::kindE           kindI,
    input  wire isaPkg::opcodeE         opI,
    input  wire [isaPkg::WORD_W-1:0]    xI,
    input  wire [isaPkg::WORD_W-1:0]    yI,
    input  wire [isaPkg::WORD_W-1:0]    immI,
    output logic                        doneO,
    output logic [isaPkg::WORD_W-1:0]   resultO
);

    logic [corePkg::EXEC_LAT-1:0]      startPipe;
    logic [isaPkg::WORD_W-1:0]         routeA;
    logic [isaPkg::WORD_W-1:0]         routeB;
    logic [isaPkg::WORD_W-1:0]         routeC;
    logic signed [isaPkg::WORD_W-1:0]  opA;
    logic signed [isaPkg::WORD_W-1:0]  opB;
    logic [isaPkg::WORD_W-1:0]         opC;
    logic [isaPkg::WORD_W-1:0]         opRes;
    logic [isaPkg::WORD_W-1:0]         opResQ;
    isaPkg::opcodeE                    opQ;

    always_comb begin
        case (kindI)
            isaPkg::KXY: {routeA, routeB, routeC} = {xI, yI, immI};
            isaPkg::KXI: {routeA, routeB, routeC} = {xI, immI, yI};
            isaPkg::KIX: {routeA, routeB, routeC} = {immI, xI, yI};
            default:     {routeA, routeB, routeC} = {{isaPkg::WORD_W{1'b0}}, xI, immI};
        endcase
    end

    always_comb begin
        opRes = '0;
        case (opQ)
            isaPkg::OP_OR:   opRes = opA | opB;
            isaPkg::OP_AND:  opRes = opA & opB;
            isaPkg::OP_XOR:  opRes = opA ^ opB;
            isaPkg::OP_SRA:  opRes = opA >>> opB;
            isaPkg::OP_ADD:  opRes = opA + opB;
            isaPkg::OP_MUL:  opRes = opA * opB;  // low word
            isaPkg::OP_EQ:   opRes = {isaPkg::WORD_W{opA == opB}};
            isaPkg::OP_LT:   opRes = {isaPkg::WORD_W{opA < opB}};
            isaPkg::OP_ORN:  opRes = opA | ~opB;
            isaPkg::OP_ANDN: opRes = opA & ~opB;
            isaPkg::OP_PACK: opRes = {opA[isaPkg::WORD_W-isaPkg::IMM_SHORT_W-1:0],
                                      opB[isaPkg::IMM_SHORT_W-1:0]};
            isaPkg::OP_SRL:  opRes = opA >> opB;
            isaPkg::OP_SUB:  opRes = opA - opB;
            isaPkg::OP_SHL:  opRes = opA << opB;
            isaPkg::OP_BTST: opRes = {isaPkg::WORD_W{|(opA & (32'd1 << opB))}};
            isaPkg::OP_GE:   opRes = {isaPkg::WORD_W{opA >= opB}};
            default:         opRes = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            startPipe <= '0;
        else
            startPipe <= {startPipe[corePkg::EXEC_LAT-2:0], startI};
    end

    // operand, op and sum stages
    always_ff @(posedge clk) begin
        if (startI) begin
            opA <= routeA;
            opB <= routeB;
            opC <= routeC;
            opQ <= opI;
        end
        if (startPipe[0])
            opResQ <= opRes;
        if (startPipe[1])
            resultO <= opResQ + opC; // held until next start
    end

    assign doneO = startPipe[corePkg::EXEC_LAT-1];

endmodule

`default_nettype wire

// File: hw/insnDecode.sv
`timescale 1ns/1ps
`default_nettype none

module insnDecode (
    input  wire [isaPkg::WORD_W-1:0]    insnI,
    output logic [isaPkg::IDX_W-1:0]    zIdxO,
    output logic [isaPkg::IDX_W-1:0]    xIdxO,
    output logic [isaPkg::IDX_W-1:0]    yIdxO,
    output isaPkg::opcodeE              opO,
    output isaPkg::kindE                kindO,
    output logic [isaPkg::WORD_W-1:0]   immO,
    output logic                        isStoreO,
    output logic                        isLoadO,
    output logic                        derefRhsO,
    output logic                        isBranchO
);

    logic [isaPkg::KIND_W-1:0]     kindBits;
    logic [isaPkg::DIR_W-1:0]      dirBits;
    logic [isaPkg::IMM_WIDE_W-1:0] tail;     // y, op and short imm, or wide imm

    assign {kindBits, dirBits, zIdxO, xIdxO, tail} = insnI;
    assign kindO = isaPkg::kindE'(kindBits);

    always_comb begin
        if (kindO == isaPkg::KWIDE) begin
            yIdxO = isaPkg::ZERO_IDX;
            opO   = isaPkg::OP_OR; // wide form is a plain or
            immO  = {{(isaPkg::WORD_W - isaPkg::IMM_WIDE_W){tail[isaPkg::IMM_WIDE_W-1]}},
                     tail};
        end else begin
            yIdxO = tail[isaPkg::IMM_WIDE_W-1 -: isaPkg::IDX_W];
            opO   = isaPkg::opcodeE'(tail[isaPkg::IMM_SHORT_W +: isaPkg::OP_W]);
            immO  = {{(isaPkg::WORD_W - isaPkg::IMM_SHORT_W){tail[isaPkg::IMM_SHORT_W-1]}},
                     tail[isaPkg::IMM_SHORT_W-1:0]};
        end
    end

    assign isStoreO  = ^dirBits;
    assign isLoadO   = &dirBits;
    assign derefRhsO = dirBits[0]; // memory at result, not at z
    assign isBranchO = (zIdxO == isaPkg::PC_IDX) && !isStoreO;

endmodule

`default_nettype wire

// File: hw/isaPkg.sv
`default_nettype none

package isaPkg;

    localparam int unsigned WORD_W      = 32;
    localparam int unsigned IDX_W       = 4;
    localparam int unsigned KIND_W      = 2;
    localparam int unsigned DIR_W       = 2;
    localparam int unsigned OP_W        = 4;
    localparam int unsigned IMM_SHORT_W = 12;
    localparam int unsigned IMM_WIDE_W  = 20;

    localparam logic [IDX_W-1:0] ZERO_IDX = 4'd0;  // hardwired zero
    localparam logic [IDX_W-1:0] PC_IDX   = 4'd15; // program counter

    typedef enum logic [OP_W-1:0] {
        OP_OR   = 4'h0,
        OP_AND  = 4'h1,
        OP_XOR  = 4'h2,
        OP_SRA  = 4'h3,
        OP_ADD  = 4'h4,
        OP_MUL  = 4'h5,
        OP_EQ   = 4'h6,
        OP_LT   = 4'h7,  // signed
        OP_ORN  = 4'h8,
        OP_ANDN = 4'h9,
        OP_PACK = 4'ha,  // a << 12 | b[11:0]
        OP_SRL  = 4'hb,
        OP_SUB  = 4'hc,
        OP_SHL  = 4'hd,
        OP_BTST = 4'he,
        OP_GE   = 4'hf   // signed
    } opcodeE;

    typedef enum logic [KIND_W-1:0] {
        KXY   = 2'b00,   // a=x b=y c=imm
        KXI   = 2'b01,   // a=x b=imm c=y
        KIX   = 2'b10,   // a=imm b=x c=y
        KWIDE = 2'b11    // a=0 b=x c=imm20
    } kindE;

endpackage

`default_nettype wire

// File: hw/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  wire                         clk,
    input  wire                         wrEnI,
    input  wire [isaPkg::IDX_W-1:0]     wrIdxI,
    input  wire [isaPkg::IDX_W-1:0]     rdXIdxI,
    input  wire [isaPkg::IDX_W-1:0]     rdYIdxI,
    input  wire [isaPkg::IDX_W-1:0]     rdZIdxI,
    input  wire [isaPkg::WORD_W-1:0]    wrDataI,
    input  wire [isaPkg::WORD_W-1:0]    nextPcI,
    output logic [isaPkg::WORD_W-1:0]   rdXO,
    output logic [isaPkg::WORD_W-1:0]   rdYO,
    output logic [isaPkg::WORD_W-1:0]   rdZO
);

    logic [isaPkg::WORD_W-1:0] regs [1:14]; // r1..r14 only

    function automatic logic [isaPkg::WORD_W-1:0] readPort(input logic [isaPkg::IDX_W-1:0] idx);
        if (idx == isaPkg::ZERO_IDX)
            return '0;
        else if (idx == isaPkg::PC_IDX)
            return nextPcI; // pc reads as next insn
        else
            return regs[idx];
    endfunction

    always_comb rdXO = readPort(rdXIdxI);
    always_comb rdYO = readPort(rdYIdxI);
    always_comb rdZO = readPort(rdZIdxI);

    always_ff @(posedge clk) begin
        if (wrEnI && wrIdxI != isaPkg::ZERO_IDX && wrIdxI != isaPkg::PC_IDX)
            regs[wrIdxI] <= wrDataI;
    end

endmodule

`default_nettype wire

// File: hw/tinyCore.sv
`timescale 1ns/1ps
`default_nettype none

module tinyCore (
    input  wire                         clk,
    input  wire                         reset,
    output logic [isaPkg::WORD_W-1:0]   adrO,
    input  wire [isaPkg::WORD_W-1:0]    datI,
    output logic [isaPkg::WORD_W-1:0]   datO,
    output logic                        wenO,
    output logic [3:0]                  selO,
    output logic                        stbO,
    input  wire                         ackI,
    input  wire                         errI,
    input  wire                         rtyI,
    output logic                        cycO,
    output logic                        haltO
);

    logic [isaPkg::WORD_W-1:0]  insn;
    logic [isaPkg::IDX_W-1:0]   zIdx;
    logic [isaPkg::IDX_W-1:0]   xIdx;
    logic [isaPkg::IDX_W-1:0]   yIdx;
    isaPkg::opcodeE             op;
    isaPkg::kindE               kind;
    logic [isaPkg::WORD_W-1:0]  imm;
    logic                       isStore;
    logic                       isLoad;
    logic                       derefRhs;
    logic                       isBranch;
    logic [isaPkg::WORD_W-1:0]  rdX;
    logic [isaPkg::WORD_W-1:0]  rdY;
    logic [isaPkg::WORD_W-1:0]  rdZ;
    logic                       execStart;
    logic                       execDone;
    logic [isaPkg::WORD_W-1:0]  result;
    logic                       rfWrEn;
    logic [isaPkg::WORD_W-1:0]  rfWrData;
    logic [isaPkg::WORD_W-1:0]  nextPc;

    assign selO  = 4'hf;        // whole words only
    assign haltO = errI | rtyI;

    insnDecode decode (
        .insnI(insn), .zIdxO(zIdx), .xIdxO(xIdx), .yIdxO(yIdx), .opO(op), .kindO(kind),
        .immO(imm), .isStoreO(isStore), .isLoadO(isLoad), .derefRhsO(derefRhs),
        .isBranchO(isBranch)
    );

    regFile regs (
        .clk(clk), .wrEnI(rfWrEn), .wrIdxI(zIdx), .rdXIdxI(xIdx), .rdYIdxI(yIdx),
        .rdZIdxI(zIdx), .wrDataI(rfWrData), .nextPcI(nextPc),
        .rdXO(rdX), .rdYO(rdY), .rdZO(rdZ)
    );

    execUnit exec (
        .clk(clk), .reset(reset), .startI(execStart), .kindI(kind), .opI(op),
        .xI(rdX), .yI(rdY), .immI(imm), .doneO(execDone), .resultO(result)
    );

    coreCtrl ctrl (
        .clk(clk), .reset(reset), .isStoreI(isStore), .isLoadI(isLoad),
        .derefRhsI(derefRhs), .isBranchI(isBranch), .resultI(result),
        .execDoneI(execDone), .rdZI(rdZ), .insnO(insn), .execStartO(execStart),
        .rfWrEnO(rfWrEn), .rfWrDataO(rfWrData), .nextPcO(nextPc),
        .adrO(adrO), .datO(datO), .wenO(wenO), .stbO(stbO), .cycO(cycO),
        .datI(datI), .ackI(ackI), .haltI(haltO)
    );

endmodule

`default_nettype wire

// File: list.f
hw/isaPkg.sv
hw/corePkg.sv
hw/regFile.sv
hw/insnDecode.sv
hw/execUnit.sv
hw/coreCtrl.sv
hw/tinyCore.sv
sim/memModel.sv
sim/tbCore.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tbCore -f list.f \
    --Mdir obj_dir -o simv
./obj_dir/simv | tee sim.log
grep -q "TEST OK" sim.log

// File: sim/memModel.sv
`timescale 1ns/1ps
`default_nettype none

module memModel (
    input  wire         clk,
    input  wire [31:0]  adrI,
    input  wire [31:0]  datI,
    input  wire         wenI,
    input  wire         stbI,
    input  wire         errReqI,
    output logic [31:0] datO,
    output logic        ackO,
    output logic        errO
);

    logic [31:0] words [0:1023];
    logic [31:0] logAdr [0:255];
    logic [31:0] logDat [0:255];
    int          writeCount = 0;
    int          waitLeft = -1;  // -1 means no transfer seen yet
    integer      seed = 32'h80661bdb;

    assign errO = errReqI;

    initial begin
        ackO = 1'b0;
        datO = '0;
        for (int i = 0; i < 1024; i++)
            words[i] = (i * 32'h9e37_79b1) ^ 32'h0bad_0000;
    end

    // ack after a random 0..3 cycle delay
    always @(negedge clk) begin
        if (ackO || !stbI) begin
            ackO = 1'b0;
            waitLeft = -1;
        end else begin
            if (waitLeft < 0)
                waitLeft = int'($unsigned($random(seed)) % 4);
            if (waitLeft == 0) begin
                ackO = 1'b1;
                datO = words[adrI[9:0]];
            end else
                waitLeft = waitLeft - 1;
        end
    end

    always @(posedge clk) begin
        if (stbI && ackO && wenI) begin
            words[adrI[9:0]] = datI;
            logAdr[writeCount[7:0]] = adrI;
            logDat[writeCount[7:0]] = datI;
            writeCount = writeCount + 1;
        end
    end

endmodule

`default_nettype wire

// File: sim/tbCore.sv
`timescale 1ns/1ps
`default_nettype none

module tbCore;

    localparam logic [31:0] BASE = corePkg::RESET_VECTOR;

    logic        clk;
    logic        reset;
    logic        rty;
    logic        errReq;
    wire  [31:0] adr;
    wire  [31:0] datToMem;
    wire  [31:0] datFromMem;
    wire  [3:0]  sel;
    wire         wen, stb, cyc, ack, err, halt;
    logic [31:0] prog [$];
    logic [31:0] reads [$];  // read addresses in bus order
    integer      seed = 32'h80661bdb;
    int          errors = 0;
    int          tests = 0;

    tinyCore dut (
        .clk(clk), .reset(reset), .adrO(adr), .datI(datFromMem), .datO(datToMem),
        .wenO(wen), .selO(sel), .stbO(stb), .ackI(ack), .errI(err), .rtyI(rty),
        .cycO(cyc), .haltO(halt)
    );

    memModel mem (
        .clk(clk), .adrI(adr), .datI(datToMem), .wenI(wen), .stbI(stb),
        .errReqI(errReq), .datO(datFromMem), .ackO(ack), .errO(err)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
        if (!reset && stb && ack && !wen)
            reads.push_back(adr);

    assert property (@(posedge clk) disable iff (reset)
        (stb && !ack) |=> ($stable(adr) && $stable(datToMem) && $stable(wen)))
        else begin
            errors++;
            $display("bus address, data or write enable changed while waiting for ack");
        end

    assert property (@(posedge clk) disable iff (reset) (cyc == stb && sel == 4'hf))
        else begin
            errors++;
            $display("mismatch cycO/selO: got %h/%h, expected %h/%h", $sampled(cyc),
                     $sampled(sel), $sampled(stb), 4'hf);
        end

    function automatic logic [31:0] encShort(isaPkg::kindE k, logic [1:0] dir, logic [3:0] z,
            logic [3:0] x, logic [3:0] y, isaPkg::opcodeE op, logic [11:0] imm);
        return {k, dir, z, x, y, op, imm};
    endfunction

    function automatic logic [31:0] encWide(logic [1:0] dir, logic [3:0] z, logic [3:0] x,
            logic [19:0] imm);
        return {isaPkg::KWIDE, dir, z, x, imm};
    endfunction

    function automatic logic [31:0] sext12(logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // expected op result for shift and bit test amounts below 32
    function automatic logic [31:0] refOp(isaPkg::opcodeE op, logic [31:0] a, logic [31:0] b);
        case (op)
            isaPkg::OP_OR:   return a | b;
            isaPkg::OP_AND:  return a & b;
            isaPkg::OP_XOR:  return a ^ b;
            isaPkg::OP_ORN:  return a | ~b;
            isaPkg::OP_ANDN: return a & ~b;
            isaPkg::OP_SRA:  return $signed(a) >>> b[4:0];
            isaPkg::OP_SRL:  return a >> b[4:0];
            isaPkg::OP_SHL:  return a << b[4:0];
            isaPkg::OP_ADD:  return a + b;
            isaPkg::OP_SUB:  return a - b;
            isaPkg::OP_MUL:  return a * b;
            isaPkg::OP_PACK: return {a[19:0], b[11:0]};
            isaPkg::OP_EQ:   return {32{a == b}};
            isaPkg::OP_LT:   return {32{$signed(a) < $signed(b)}};
            isaPkg::OP_GE:   return {32{$signed(a) >= $signed(b)}};
            isaPkg::OP_BTST: return {32{a[b[4:0]]}};
            default:         return '0;
        endcase
    endfunction

    task automatic putReg(input logic [3:0] r, input logic [31:0] v);
        prog.push_back(encWide(2'b00, r, 4'd0, v[31:12]));
        prog.push_back(encShort(isaPkg::KXI, 2'b00, r, r, 4'd0, isaPkg::OP_PACK, v[11:0]));
    endtask

    // store z at the immediate address
    task automatic putStore(input logic [3:0] r, input logic [19:0] addr);
        prog.push_back(encWide(2'b01, r, 4'd0, addr));
    endtask

    task automatic startProgram();
        prog.push_back(encWide(2'b00, 4'd15, 4'd0, 20'(int'(BASE) + prog.size()))); // spin
        @(negedge clk);
        for (int i = 0; i < prog.size(); i++)
            mem.words[int'(BASE) + i] = prog[i];
        prog.delete();
        reset = 1'b1;
        repeat (2) @(negedge clk);
        reset = 1'b0;
        mem.writeCount = 0;
        reads.delete();
    endtask

    task automatic waitWrites(input int n);
        int cycles = 0;
        while (mem.writeCount < n && cycles < 3000) begin
            @(negedge clk);
            cycles++;
        end
        if (mem.writeCount < n) begin
            errors++;
            $display("timeout, only %0d of %0d memory writes arrived", mem.writeCount, n);
        end
    endtask

    task automatic checkWrite(input int idx, input logic [31:0] expAdr, input logic [31:0] expDat);
        assert (mem.logAdr[idx] == expAdr && mem.logDat[idx] == expDat) else begin
            errors++;
            $display("mismatch adrO/datO write %0d: got %h/%h, expected %h/%h", idx,
                     mem.logAdr[idx], mem.logDat[idx], expAdr, expDat);
        end
    endtask

    task automatic report(input string name, input int errBefore);
        tests++;
        $display("%s: %s", name, (errors == errBefore) ? "pass" : "fail");
    endtask

    initial begin
        logic [31:0] x, y, ys, rnd, v;
        logic [11:0] imms [16];
        isaPkg::opcodeE op;
        int e;
        reset = 1'b1;
        rty = 1'b0;
        errReq = 1'b0;

        e = errors;
        prog.push_back(encWide(2'b00, 4'd11, 4'd0, 20'h12345));
        putStore(4'd11, 20'h280);
        startProgram();
        assert (stb && !wen && adr == BASE) else begin
            errors++;
            $display("mismatch adrO: got %h, expected %h (stbO %h wenO %h)", adr, BASE, stb, wen);
        end
        waitWrites(1);
        checkWrite(0, 32'h280, 32'h12345);
        report("reset fetch", e);

        e = errors;
        x = $random(seed);
        y = $random(seed);
        ys = y & 32'd31;
        putReg(4'd1, x);
        putReg(4'd2, y);
        putReg(4'd4, ys);
        for (int i = 0; i < 16; i++) begin
            op = isaPkg::opcodeE'(i);
            rnd = $random(seed);
            imms[i] = rnd[11:0];
            prog.push_back(encShort(isaPkg::KXY, 2'b00, 4'd3, 4'd1,
                (op inside {isaPkg::OP_SRA, isaPkg::OP_SRL, isaPkg::OP_SHL, isaPkg::OP_BTST})
                    ? 4'd4 : 4'd2, op, imms[i]));
            putStore(4'd3, 20'h200 + 20'(i));
        end
        startProgram();
        waitWrites(16);
        for (int i = 0; i < 16; i++) begin
            op = isaPkg::opcodeE'(i);
            v = (op inside {isaPkg::OP_SRA, isaPkg::OP_SRL, isaPkg::OP_SHL, isaPkg::OP_BTST})
                ? ys : y;
            checkWrite(i, 32'h200 + i, refOp(op, x, v) + sext12(imms[i]));
        end
        report("opcodes KXY", e);

        e = errors;
        x = $random(seed);
        y = $random(seed);
        putReg(4'd1, x);
        putReg(4'd2, y);
        prog.push_back(encShort(isaPkg::KXI, 2'b00, 4'd5, 4'd1, 4'd2, isaPkg::OP_SUB, 12'hffb));
        putStore(4'd5, 20'h220);
        prog.push_back(encShort(isaPkg::KIX, 2'b00, 4'd5, 4'd1, 4'd2, isaPkg::OP_SUB, 12'hed4));
        putStore(4'd5, 20'h221);
        prog.push_back(encWide(2'b00, 4'd5, 4'd1, 20'hEEE90)); // -70000
        putStore(4'd5, 20'h222);
        startProgram();
        waitWrites(3);
        checkWrite(0, 32'h220, refOp(isaPkg::OP_SUB, x, sext12(12'hffb)) + y);
        checkWrite(1, 32'h221, refOp(isaPkg::OP_SUB, sext12(12'hed4), x) + y);
        checkWrite(2, 32'h222, x - 32'd70000);
        report("kinds and immediates", e);

        e = errors;
        v = $random(seed);
        mem.words[32'h240] = v;
        prog.push_back(encWide(2'b00, 4'd6, 4'd0, 20'h230));
        prog.push_back(encShort(isaPkg::KXI, 2'b11, 4'd7, 4'd6, 4'd0, isaPkg::OP_ADD, 12'h010));
        prog.push_back(encWide(2'b00, 4'd8, 4'd0, 20'h250));
        prog.push_back(encShort(isaPkg::KXY, 2'b10, 4'd8, 4'd7, 4'd0, isaPkg::OP_OR, 12'h000));
        prog.push_back(encWide(2'b00, 4'd0, 4'd0, 20'h0007b));
        putStore(4'd0, 20'h251);
        startProgram();
        waitWrites(2);
        checkWrite(0, 32'h250, v);
        checkWrite(1, 32'h251, 32'h0);
        report("load, store and r0", e);

        e = errors;
        prog.push_back(encShort(isaPkg::KXI, 2'b00, 4'd15, 4'd15, 4'd0, isaPkg::OP_ADD,
            12'd2)); // pc relative
        putStore(4'd0, 20'h260); // skipped
        putStore(4'd0, 20'h260);
        putStore(4'd15, 20'h261);
        startProgram();
        waitWrites(1);
        checkWrite(0, 32'h261, BASE + 32'd4);
        assert (reads.size() > 1 && reads[1] == BASE + 32'd3) else begin
            errors++;
            $display("mismatch adrO: got %h, expected %h", (reads.size() > 1) ? reads[1] : 32'hx,
                     BASE + 32'd3);
        end
        report("branch", e);

        e = errors;
        prog.push_back(encWide(2'b00, 4'd9, 4'd0, 20'd77));
        putStore(4'd9, 20'h270);
        prog.push_back(encShort(isaPkg::KXI, 2'b00, 4'd10, 4'd9, 4'd0, isaPkg::OP_ADD, 12'd5));
        putStore(4'd10, 20'h271);
        startProgram();
        errReq = 1'b1;
        #1;
        assert (halt) else begin
            errors++;
            $display("haltO did not follow errI");
        end
        repeat (30) @(negedge clk);
        assert (mem.writeCount == 0) else begin
            errors++;
            $display("a memory write arrived while the core was halted");
        end
        errReq = 1'b0;
        rty = 1'b1;
        #1;
        assert (halt) else begin
            errors++;
            $display("haltO did not follow rtyI");
        end
        @(negedge clk);
        rty = 1'b0;
        waitWrites(2);
        checkWrite(0, 32'h270, 32'd77);
        checkWrite(1, 32'h271, 32'd82);
        report("halt on error", e);

        $display("%0d tests, %0d errors", tests, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire
